// ==== Bender.yml ====
package:
  name: vga_display

sources:
  - include_dirs:
      - src
    files:
      - src/cam_pkg.sv
      - src/fb_host_regs.sv
      - src/vga_timing.sv
      - src/frame_buffer.sv
      - src/vga_pixel_pipe.sv
      - src/vga_display_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_vga_display.sv

// ==== dv/pixel_vectors.txt ====
// x y rgb565 red green blue gray, all hex
// red, green and blue expanded with low bits set to one
000 00 0000 07 03 07 04
13f 00 ffff ff ff ff fb
000 ef f800 ff 03 07 4e
13f ef 07e0 07 ff 07 98
0a0 78 001f 07 03 ff 1d
001 00 8410 87 83 87 82
000 01 1234 17 47 a7 41
064 32 abcd af 7b 6f 87
0c8 c7 ffe0 ff ff 07 e1
025 58 f81f ff 03 ff 67
0fa 03 07ff 07 ff ff b1
13e ee 5aeb 5f 5f 5f 5d

// ==== dv/tb_vga_display.sv ====
/* VGA display testbench */
`timescale 1ns/1ps
`include "vga_defs.svh"

module tb_vga_display
    import cam_pkg::*;
();

    localparam int NUM_VEC   = 12;
    localparam int RESP_WAIT = 16;  // max cycles for a response
    localparam int OKAY      = 0;
    localparam int SLVERR    = 2;

    logic                   clk_25_vga;
    logic                   rst;
    logic                   awvalid;
    logic                   awready;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    host_word_u             wdata;
    logic [3:0]             wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [`AXI_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic [7:0]             vga_r;
    logic [7:0]             vga_g;
    logic [7:0]             vga_b;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic                   vga_blank_n;

    logic [15:0] vec_mem [NUM_VEC*7];  // x y rgb565 r g b gray
    int          vec_at [`FB_DEPTH];   // buffer index to vector, -1 if none
    logic [31:0] lfsr = 32'h8493_e9c6;
    int          err_count = 0;
    logic        mon_en = 1'b0;
    logic        hs_q = 1'b1;
    logic        vs_q = 1'b1;
    logic        bl_q = 1'b0;
    logic        hs_seen = 1'b0;
    int          hs_cnt = 0;
    int          hs_low = 0;
    int          vs_low = 0;
    int          bl_run = 0;
    int          act_lines = 0;
    int          aw_pulses = 0;
    int          w_pulses = 0;
    int          ar_pulses = 0;

    vga_display_top vga_display_top_inst (.*);

    initial begin
        clk_25_vga = 1'b0;
        forever #20 clk_25_vga = ~clk_25_vga;  // 25 MHz
    end

    // four frames of 420000 cycles plus margin
    initial begin
        #(64'd4 * 420000 * 40 + 64'd2_000_000);
        abort_run("timeout, the display never finished the checked frames");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        if (act !== exp) begin
            err_count++;
            $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            abort_run("signal mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int val);
        val = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            val = (val << 1) | lfsr[0];
        end
    endtask

    function automatic logic [`AXI_ADDR_W-1:0] pix_addr(input int idx);
        return `AXI_ADDR_W'(1 << `PIX_REGION_BIT) | `AXI_ADDR_W'(idx << 2);
    endfunction

    // ready pulses, taken before the edge updates the DUT
    always @(posedge clk_25_vga) begin
        if (awready) aw_pulses++;
        if (wready) w_pulses++;
        if (arready) ar_pulses++;
    end

    // starts and ends on a falling edge
    task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [31:0] data, output logic [1:0] resp);
        int waited;
        int delay;
        int aw_start;
        int w_start;
        aw_start = aw_pulses;
        w_start  = w_pulses;
        awaddr   = addr;
        wdata    = data;
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk_25_vga);
            waited++;
            if (waited > RESP_WAIT) abort_run("write response never arrived");
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        rand_bits(3, delay);
        repeat (delay) begin
            @(negedge clk_25_vga);
            check_eq("bvalid", 1, bvalid);  // held until bready
        end
        bready = 1'b1;
        @(negedge clk_25_vga);
        bready = 1'b0;
        check_eq("bvalid", 0, bvalid);
        check_eq("awready pulses", 1, aw_pulses - aw_start);
        check_eq("wready pulses", 1, w_pulses - w_start);
    endtask

    task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr,
                            output logic [31:0] data, output logic [1:0] resp);
        int waited;
        int delay;
        int ar_start;
        ar_start = ar_pulses;
        araddr   = addr;
        arvalid  = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk_25_vga);
            waited++;
            if (waited > RESP_WAIT) abort_run("read data never arrived");
        end while (!rvalid);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        rand_bits(3, delay);
        repeat (delay) begin
            @(negedge clk_25_vga);
            check_eq("rvalid", 1, rvalid);
        end
        rready = 1'b1;
        @(negedge clk_25_vga);
        rready = 1'b0;
        check_eq("rvalid", 0, rvalid);
        check_eq("arready pulses", 1, ar_pulses - ar_start);
    endtask

    task automatic check_reset_state();
        check_eq("vga_hsync", 1, vga_hsync);
        check_eq("vga_vsync", 1, vga_vsync);
        check_eq("vga_blank_n", 0, vga_blank_n);
        check_eq("vga_r", 0, vga_r);
        check_eq("vga_g", 0, vga_g);
        check_eq("vga_b", 0, vga_b);
        check_eq("bvalid", 0, bvalid);
        check_eq("rvalid", 0, rvalid);
    endtask

    // one frame after the next vsync pulse, each vector on its 2x2 block
    task automatic check_frame(input logic gray_on);
        int         line;
        int         col;
        int         sy;
        int         v;
        int         hits;
        logic       hs_prev;
        logic [7:0] exp_r;
        logic [7:0] exp_g;
        logic [7:0] exp_b;
        while (vga_vsync) @(negedge clk_25_vga);
        while (!vga_vsync) @(negedge clk_25_vga);
        line    = 0;
        col     = 0;
        hits    = 0;
        hs_prev = vga_hsync;
        while (vga_vsync) begin
            @(negedge clk_25_vga);
            if (hs_prev && !vga_hsync) line++;  // back porch lines counted too
            hs_prev = vga_hsync;
            if (!vga_blank_n) begin
                col = 0;
            end else begin
                sy = line - `V_BACK;
                v  = -1;
                if (sy >= 0 && sy < `V_ACTIVE && col < `H_ACTIVE) begin
                    v = vec_at[(sy / 2) * `FB_W + col / 2];
                end
                col++;
                if (v >= 0) begin
                    exp_r = gray_on ? vec_mem[v*7+6][7:0] : vec_mem[v*7+3][7:0];
                    exp_g = gray_on ? vec_mem[v*7+6][7:0] : vec_mem[v*7+4][7:0];
                    exp_b = gray_on ? vec_mem[v*7+6][7:0] : vec_mem[v*7+5][7:0];
                    check_eq("vga_r", exp_r, vga_r);
                    check_eq("vga_g", exp_g, vga_g);
                    check_eq("vga_b", exp_b, vga_b);
                    hits++;
                end
            end
        end
        check_eq("checked pixel count", NUM_VEC * 4, hits);
    endtask

    // raster shape and blanking, sampled mid-cycle
    always @(negedge clk_25_vga) begin
        if (mon_en) begin
            if (!vga_blank_n) begin
                check_eq("vga_r", 0, vga_r);
                check_eq("vga_g", 0, vga_g);
                check_eq("vga_b", 0, vga_b);
            end
            if (hs_q && !vga_hsync) begin
                if (hs_seen) begin
                    check_eq("hsync period", `H_TOTAL, hs_cnt);
                end
                hs_seen = 1'b1;
                hs_cnt  = 0;
            end
            hs_cnt++;
            if (!hs_q && vga_hsync) check_eq("hsync low time", `H_SYNC, hs_low);
            hs_low = vga_hsync ? 0 : hs_low + 1;
            if (!vs_q && vga_vsync) check_eq("vsync low time", `V_SYNC * `H_TOTAL, vs_low);
            vs_low = vga_vsync ? 0 : vs_low + 1;
            if (vs_q && !vga_vsync) begin
                check_eq("active lines", `V_ACTIVE, act_lines);
                act_lines = 0;
            end
            if (bl_q && !vga_blank_n) begin
                check_eq("blank_n high time", `H_ACTIVE, bl_run);
                act_lines++;
            end
            bl_run = vga_blank_n ? bl_run + 1 : 0;
            hs_q   = vga_hsync;
            vs_q   = vga_vsync;
            bl_q   = vga_blank_n;
        end
    end

    initial begin : main
        int          i;
        int          idx;
        logic [1:0]  resp;
        logic [31:0] data;
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        $readmemh("dv/pixel_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*7-1])) abort_run("pixel vector file missing or short");
        for (i = 0; i < `FB_DEPTH; i++) vec_at[i] = -1;
        repeat (8) begin
            @(negedge clk_25_vga);
            check_reset_state();
        end
        rst = 1'b0;
        @(negedge clk_25_vga);
        check_reset_state();  // pipeline still holds reset values
        mon_en = 1'b1;

        axi_write(`MODE_ADDR, 32'd1, resp);
        check_eq("bresp", OKAY, resp);
        axi_read(`MODE_ADDR, data, resp);
        check_eq("rresp", OKAY, resp);
        check_eq("rdata", 1, data);
        axi_write(`MODE_ADDR, 32'd0, resp);
        check_eq("bresp", OKAY, resp);
        axi_read(`MODE_ADDR, data, resp);
        check_eq("rresp", OKAY, resp);
        check_eq("rdata", 0, data);

        axi_write(`AXI_ADDR_W'('h4), 32'd1, resp);  // unmapped
        check_eq("bresp", SLVERR, resp);
        axi_write(pix_addr(`FB_DEPTH), 32'hffff, resp);  // one past the last pixel
        check_eq("bresp", SLVERR, resp);
        axi_read(pix_addr(0), data, resp);
        check_eq("rresp", SLVERR, resp);
        check_eq("rdata", 0, data);

        for (i = 0; i < NUM_VEC; i++) begin
            idx = vec_mem[i*7+1] * `FB_W + vec_mem[i*7];
            vec_at[idx] = i;
            axi_write(pix_addr(idx), {16'h0, vec_mem[i*7+2]}, resp);
            check_eq("bresp", OKAY, resp);
        end
        check_frame(1'b0);

        axi_write(`MODE_ADDR, 32'd1, resp);  // gray from the next frame
        check_eq("bresp", OKAY, resp);
        check_frame(1'b1);

        if (err_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("checks failed");
        end
    end

endmodule

// ==== sources.f ====
+incdir+src
src/cam_pkg.sv
src/fb_host_regs.sv
src/vga_timing.sv
src/frame_buffer.sv
src/vga_pixel_pipe.sv
src/vga_display_top.sv
dv/tb_vga_display.sv

// ==== src/cam_pkg.sv ====
/* Host word types */
package cam_pkg;

    // rgb565 pixel as written by the host
    typedef struct packed {
        logic [15:0] pad;
        logic [4:0]  red;
        logic [5:0]  green;
        logic [4:0]  blue;
    } pix_view_t;

    // mode register layout
    typedef struct packed {
        logic [30:0] pad;
        logic        gray_en;
    } ctrl_view_t;

    // one 32-bit bus word, decoded by address
    typedef union packed {
        pix_view_t  pix;
        ctrl_view_t ctrl;
    } host_word_u;

endpackage

// ==== src/fb_host_regs.sv ====
/* AXI4-Lite host port
   mode register and pixel writes */
`timescale 1ns/1ps
`include "vga_defs.svh"

module fb_host_regs
    import cam_pkg::*;
(
    input  logic                   clk_25_vga,
    input  logic                   rst,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  host_word_u             wdata,
    input  logic [3:0]             wstrb,     // full-word writes only
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   fb_we,
    output logic [`FB_ADDR_W-1:0]  fb_waddr,
    output logic [`PIX_W-1:0]      fb_wdata,
    output host_word_u             mode
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                  wr_accept;
    logic                  rd_accept;
    logic                  wr_is_mode;
    logic                  wr_is_pix;
    logic                  wr_pix_ok;
    logic [`FB_ADDR_W-1:0] wr_idx;
    logic                  rd_is_mode;

    // both channels must be present and the last response taken
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign rd_accept = arvalid & ~rvalid;

    assign awready = wr_accept; // one-cycle pulse on accept
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // address decode
    assign wr_is_mode = (awaddr == `MODE_ADDR);
    assign wr_is_pix  = awaddr[`PIX_REGION_BIT];
    assign wr_idx     = awaddr[`PIX_REGION_BIT-1:2]; // y*320 + x
    assign wr_pix_ok  = wr_is_pix && (wr_idx < `FB_DEPTH);
    assign rd_is_mode = (araddr == `MODE_ADDR);

    // buffer written in the accept cycle
    assign fb_we    = wr_accept & wr_pix_ok;
    assign fb_waddr = wr_idx;
    assign fb_wdata = {wdata.pix.red, wdata.pix.green, wdata.pix.blue};

    // mode register
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            mode <= '0;
        end else if (wr_accept && wr_is_mode) begin
            mode.ctrl.pad     <= '0;
            mode.ctrl.gray_en <= wdata.ctrl.gray_en; // ctrl view of the bus word
        end
    end

    // write response channel
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            bresp  <= (wr_is_mode || wr_pix_ok) ? RESP_OKAY : RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0; // held until taken
        end
    end

    // read data channel
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= RESP_OKAY;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
            if (rd_is_mode) begin
                rdata <= {{(`AXI_DATA_W-1){1'b0}}, mode.ctrl.gray_en};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0; // nothing else readable
                rresp <= RESP_SLVERR;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// ==== src/frame_buffer.sv ====
/* Frame buffer RAM */
`timescale 1ns/1ps
`include "vga_defs.svh"

module frame_buffer (
    input  logic                  clk_25_vga,
    input  logic                  we,
    input  logic [`FB_ADDR_W-1:0] waddr,
    input  logic [`PIX_W-1:0]     wdata,
    input  logic [`FB_ADDR_W-1:0] raddr,
    output logic [`PIX_W-1:0]     rdata
);

    logic [`PIX_W-1:0] mem [`FB_DEPTH]; // 320x240 rgb565

    always_ff @(posedge clk_25_vga) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle
    always_ff @(posedge clk_25_vga) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== src/vga_defs.svh ====
/* VGA display path
   timing, geometry and host map */
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// 640x480 at 60 Hz, pixel clock 25 MHz
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// frame buffer, shown 2x upscaled
`define FB_W 320
`define FB_H 240
`define FB_DEPTH 76800
`define FB_ADDR_W 17

`define PIX_W 16 // rgb565 word

// host port
`define AXI_ADDR_W 20
`define AXI_DATA_W 32

`define MODE_ADDR 20'h00000
`define PIX_REGION_BIT 19 // set for pixel window, index in bits 18:2

// timing outputs to vga pins
`define PIPE_LAT 2

`endif

// ==== src/vga_display_top.sv ====
/* VGA display top */
`timescale 1ns/1ps
`include "vga_defs.svh"

module vga_display_top
    import cam_pkg::*;
(
    input  logic                   clk_25_vga,
    input  logic                   rst,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  host_word_u             wdata,
    input  logic [3:0]             wstrb,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic [7:0]             vga_r,
    output logic [7:0]             vga_g,
    output logic [7:0]             vga_b,
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic                   vga_blank_n
);

    logic                  fb_we;
    logic [`FB_ADDR_W-1:0] fb_waddr;
    logic [`PIX_W-1:0]     fb_wdata;
    host_word_u            mode;
    logic                  hsync_raw;
    logic                  vsync_raw;
    logic                  active_raw;
    logic [`FB_ADDR_W-1:0] rd_addr;
    logic [`PIX_W-1:0]     rd_data;

    fb_host_regs fb_host_regs_inst (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .fb_we      (fb_we),
        .fb_waddr   (fb_waddr),
        .fb_wdata   (fb_wdata),
        .mode       (mode)
    );

    vga_timing vga_timing_inst (
        .clk_25_vga (clk_25_vga),
        .rst        (rst),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .active_raw (active_raw),
        .rd_addr    (rd_addr)
    );

    frame_buffer frame_buffer_inst (
        .clk_25_vga (clk_25_vga),
        .we         (fb_we),
        .waddr      (fb_waddr),
        .wdata      (fb_wdata),
        .raddr      (rd_addr),
        .rdata      (rd_data)
    );

    vga_pixel_pipe vga_pixel_pipe_inst (
        .clk_25_vga  (clk_25_vga),
        .rst         (rst),
        .pix         (rd_data),
        .mode        (mode),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .active_raw  (active_raw),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

endmodule

// ==== src/vga_pixel_pipe.sv ====
/* VGA pixel output stage */
`timescale 1ns/1ps
`include "vga_defs.svh"

module vga_pixel_pipe
    import cam_pkg::*;
(
    input  logic              clk_25_vga,
    input  logic              rst,
    input  logic [`PIX_W-1:0] pix,
    input  host_word_u        mode,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    input  logic              active_raw,
    output logic [7:0]        vga_r,
    output logic [7:0]        vga_g,
    output logic [7:0]        vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic              vga_blank_n
);

    logic [7:0]  r8;
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic [15:0] gray_sum;
    logic [7:0]  gray;
    logic        hs_d1;
    logic        vs_d1;
    logic        act_d1; // lines up with pix

    // rgb565 to rgb888, low bits filled with ones
    assign r8 = {pix[15:11], 3'b111};
    assign g8 = {pix[10:5], 2'b11};
    assign b8 = {pix[4:0], 3'b111};

    // 76r + 150g + 26b
    assign gray_sum = (16'(r8) << 6) + (16'(r8) << 3) + (16'(r8) << 2)
                    + (16'(g8) << 7) + (16'(g8) << 4) + (16'(g8) << 2) + (16'(g8) << 1)
                    + (16'(b8) << 4) + (16'(b8) << 3) + (16'(b8) << 1);
    assign gray = gray_sum[15:8];

    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            hs_d1       <= 1'b1;
            vs_d1       <= 1'b1;
            act_d1      <= 1'b0;
            vga_hsync   <= 1'b1;
            vga_vsync   <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_r       <= '0;
            vga_g       <= '0;
            vga_b       <= '0;
        end else begin
            hs_d1       <= hsync_raw; // stage 1, ram read
            vs_d1       <= vsync_raw;
            act_d1      <= active_raw;
            vga_hsync   <= hs_d1;     // stage 2, output register
            vga_vsync   <= vs_d1;
            vga_blank_n <= act_d1;
            if (!act_d1) begin
                vga_r <= '0;
                vga_g <= '0;
                vga_b <= '0;
            end else if (mode.ctrl.gray_en) begin
                vga_r <= gray;
                vga_g <= gray;
                vga_b <= gray;
            end else begin
                vga_r <= r8;
                vga_g <= g8;
                vga_b <= b8;
            end
        end
    end

endmodule

// ==== src/vga_timing.sv ====
/* VGA raster timing */
`timescale 1ns/1ps
`include "vga_defs.svh"

module vga_timing (
    input  logic                  clk_25_vga,
    input  logic                  rst,
    output logic                  hsync_raw,
    output logic                  vsync_raw,
    output logic                  active_raw,
    output logic [`FB_ADDR_W-1:0] rd_addr
);

    localparam int H_W = $clog2(`H_TOTAL);
    localparam int V_W = $clog2(`V_TOTAL);

    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END   = VS_START + `V_SYNC;

    logic [H_W-1:0]        h_cnt;
    logic [V_W-1:0]        v_cnt;
    logic [`FB_ADDR_W-1:0] line_base; // (v/2)*320
    logic                  h_last;
    logic                  active;

    assign h_last = (h_cnt == H_W'(`H_TOTAL - 1));
    assign active = (h_cnt < H_W'(`H_ACTIVE)) && (v_cnt < V_W'(`V_ACTIVE));

    // column and row counters, line base stepped every second line
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            line_base <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_cnt == V_W'(`V_TOTAL - 1)) begin
                v_cnt     <= '0;
                line_base <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
                if (v_cnt[0]) begin
                    line_base <= line_base + `FB_ADDR_W'(`FB_W); // next buffer row
                end
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // registered outputs, negative syncs
    always_ff @(posedge clk_25_vga) begin
        if (rst) begin
            hsync_raw  <= 1'b1;
            vsync_raw  <= 1'b1;
            active_raw <= 1'b0;
            rd_addr    <= '0;
        end else begin
            hsync_raw  <= ~((h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_END)));
            vsync_raw  <= ~((v_cnt >= V_W'(VS_START)) && (v_cnt < V_W'(VS_END)));
            active_raw <= active;
            rd_addr    <= active ? line_base + `FB_ADDR_W'(h_cnt[H_W-1:1]) : '0;
        end
    end

endmodule
